// ==== filelist.f ====
hdl/lotrCfgPkg.sv
hdl/lotrPkg.sv
hdl/c2fRequest.sv
hdl/ringReqFifo.sv
hdl/ringStop.sv
hdl/ringNode.sv
sim/ringNodeChecker.sv
sim/ringNodeTb.sv

// ==== hdl/c2fRequest.sv ====
//----------------------------------------------------------
// Core to fabric request stage
// Registers a core request and tags it with the requestor id
// made of this node's core id and the issuing thread id
//----------------------------------------------------------
`timescale 1ns/1ps

module c2fRequest
    import lotrCfgPkg::*;
    import lotrPkg::*;
(
    // General
    input  logic                 QClk,
    input  logic                 reset,
    input  logic [CORE_ID_W-1:0] coreId,

    // From core
    input  tCoreReq              coreReq,

    // To request buffer, valid is the push strobe
    output tRingMsg              fifoWrite
);

    // Tagged message before the register
    tRingMsg reqMsg;

    //----------------------------------------------------------
    // Message build
    //----------------------------------------------------------
    always_comb begin
        reqMsg.valid     = coreReq.valid;
        reqMsg.opcode    = coreReq.opcode;
        // Who asked travels with the message
        reqMsg.requestor = {coreId, coreReq.threadId};
        reqMsg.address   = coreReq.address;
        reqMsg.data      = coreReq.data;
    end

    //----------------------------------------------------------
    // Request register, one cycle to the buffer
    //----------------------------------------------------------
    always_ff @(posedge QClk) begin
        // Payload taken every cycle
        fifoWrite <= reqMsg;
        // Only the strobe is cleared
        if (reset) begin
            fifoWrite.valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/lotrCfgPkg.sv ====
//----------------------------------------------------------
// Ring node configuration
// Field widths, id sizes and request buffer depth
//----------------------------------------------------------
package lotrCfgPkg;

    // Address and data fields, one word each
    localparam int DATA_W = 32;

    // Requestor identity parts
    localparam int CORE_ID_W   = 8;
    localparam int THREAD_ID_W = 2;

    // Core id in the upper bits, thread id in the lower bits
    localparam int REQUESTOR_W = CORE_ID_W + THREAD_ID_W;

    //----------------------------------------------------------
    // Local request buffer
    //----------------------------------------------------------
    localparam int REQ_FIFO_DEPTH = 4;
    // Pointer width for the depth above
    localparam int REQ_FIFO_PTR_W = 2;

endpackage

// ==== hdl/lotrPkg.sv ====
//----------------------------------------------------------
// Ring message format
// Opcodes, slot winner codes, ring message and core structs
//----------------------------------------------------------
package lotrPkg;
    import lotrCfgPkg::*;

    // Message opcodes, only the two responses are ejected
    typedef enum logic [1:0] {
        RD     = 2'b00,
        WR     = 2'b01,
        RD_RSP = 2'b10,
        WR_RSP = 2'b11
    } tOpcode;

    // Source that took the ring slot this cycle
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        FORWARD = 2'b01,
        EJECT   = 2'b10,
        INSERT  = 2'b11
    } tWinner;

    //----------------------------------------------------------
    // Ring slot contents, also the buffer entry
    //----------------------------------------------------------
    typedef struct packed {
        logic                   valid;
        tOpcode                 opcode;
        // Upper bits core id, lower bits thread id
        logic [REQUESTOR_W-1:0] requestor;
        logic [DATA_W-1:0]      address;
        logic [DATA_W-1:0]      data;
    } tRingMsg;

    // Core to node request
    typedef struct packed {
        logic                   valid;
        tOpcode                 opcode;
        logic [DATA_W-1:0]      address;
        logic [DATA_W-1:0]      data;
        logic [THREAD_ID_W-1:0] threadId;
    } tCoreReq;

    // Node to core response
    typedef struct packed {
        logic                   valid;
        tOpcode                 opcode;
        logic [DATA_W-1:0]      data;
        logic [THREAD_ID_W-1:0] threadId;
    } tCoreRsp;

endpackage

// ==== hdl/ringNode.sv ====
//----------------------------------------------------------
// Ring node top
// Request stage, local request buffer and ring stop
//----------------------------------------------------------
`timescale 1ns/1ps

module ringNode
    import lotrCfgPkg::*;
    import lotrPkg::*;
(
    // General
    input  logic                 QClk,
    input  logic                 reset,
    input  logic [CORE_ID_W-1:0] coreId,

    // Core side
    input  tCoreReq              coreReq,
    output logic                 coreStall,
    output tCoreRsp              coreRsp,

    // Ring side
    input  tRingMsg              ringIn,
    output tRingMsg              ringOut,

    // Debug
    output tWinner               slotWinner
);

    // Request stage to buffer
    tRingMsg fifoWrite;
    // Buffer to ring stop
    tRingMsg fifoHead;
    logic    fifoPop;

    // Tag and register core requests
    c2fRequest u_c2fRequest (
        .QClk      (QClk),
        .reset     (reset),
        .coreId    (coreId),
        .coreReq   (coreReq),
        .fifoWrite (fifoWrite)
    );

    // Full level is the core stall
    ringReqFifo u_ringReqFifo (
        .QClk      (QClk),
        .reset     (reset),
        .fifoWrite (fifoWrite),
        .fifoPop   (fifoPop),
        .fifoHead  (fifoHead),
        .fifoFull  (coreStall)
    );

    // Ring slot owner
    ringStop u_ringStop (
        .QClk       (QClk),
        .reset      (reset),
        .coreId     (coreId),
        .ringIn     (ringIn),
        .fifoHead   (fifoHead),
        .fifoPop    (fifoPop),
        .ringOut    (ringOut),
        .coreRsp    (coreRsp),
        .slotWinner (slotWinner)
    );

endmodule

// ==== hdl/ringReqFifo.sv ====
//----------------------------------------------------------
// Local ring request buffer
// Circular FIFO holding requests until a ring slot is free
//----------------------------------------------------------
`timescale 1ns/1ps

module ringReqFifo
    import lotrCfgPkg::*;
    import lotrPkg::*;
(
    input  logic    QClk,
    input  logic    reset,

    // Push side, valid is the push strobe
    input  tRingMsg fifoWrite,

    // Pop side, head valid means not empty
    input  logic    fifoPop,
    output tRingMsg fifoHead,
    output logic    fifoFull
);

    // Entry storage
    tRingMsg                  mem [REQ_FIFO_DEPTH];

    logic [REQ_FIFO_PTR_W-1:0] wrPtr;
    logic [REQ_FIFO_PTR_W-1:0] rdPtr;
    // One extra bit to hold the full count
    logic [REQ_FIFO_PTR_W:0]   count;

    logic                      notEmpty;
    logic                      push;
    logic                      pop;

    // Status
    assign notEmpty = (count != '0);
    assign fifoFull = (count == (REQ_FIFO_PTR_W+1)'(REQ_FIFO_DEPTH));

    // Push while full is dropped
    assign push = fifoWrite.valid && !fifoFull;
    assign pop  = fifoPop && notEmpty;

    //----------------------------------------------------------
    // Pointers and occupancy
    //----------------------------------------------------------
    always_ff @(posedge QClk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == REQ_FIFO_PTR_W'(REQ_FIFO_DEPTH-1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == REQ_FIFO_PTR_W'(REQ_FIFO_DEPTH-1)) ? '0 : rdPtr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage write
    always_ff @(posedge QClk) begin
        if (push) begin
            mem[wrPtr] <= fifoWrite;
        end
    end

    // Head seen the cycle after its push
    always_comb begin
        fifoHead       = mem[rdPtr];
        fifoHead.valid = notEmpty;
    end

endmodule

// ==== hdl/ringStop.sv ====
//----------------------------------------------------------
// Ring stop
// Ejects responses for this core, forwards passing traffic
// and inserts the oldest local request into a free slot
//----------------------------------------------------------
`timescale 1ns/1ps

module ringStop
    import lotrCfgPkg::*;
    import lotrPkg::*;
(
    // General
    input  logic                 QClk,
    input  logic                 reset,
    input  logic [CORE_ID_W-1:0] coreId,

    // Ring upstream
    input  tRingMsg              ringIn,

    // Local request buffer
    input  tRingMsg              fifoHead,
    output logic                 fifoPop,

    // Ring downstream and core response
    output tRingMsg              ringOut,
    output tCoreRsp              coreRsp,

    // Debug view of the slot decision
    output tWinner               slotWinner
);

    logic    isRsp;
    logic    idMatch;
    logic    rspMatch;
    tWinner  winner;
    tRingMsg nextOut;
    tCoreRsp nextRsp;

    //----------------------------------------------------------
    // Incoming message decode
    //----------------------------------------------------------
    assign isRsp    = (ringIn.opcode == RD_RSP) || (ringIn.opcode == WR_RSP);
    // Core id sits in the upper requestor bits
    assign idMatch  = (ringIn.requestor[REQUESTOR_W-1:THREAD_ID_W] == coreId);
    assign rspMatch = ringIn.valid && isRsp && idMatch;

    //----------------------------------------------------------
    // Slot decision
    //----------------------------------------------------------
    always_comb begin
        if (ringIn.valid && !rspMatch) begin
            // Passing traffic always keeps the slot
            winner = FORWARD;
        end else if (fifoHead.valid) begin
            // Free slot, including one freed by an eject
            winner = INSERT;
        end else if (rspMatch) begin
            winner = EJECT;
        end else begin
            winner = IDLE;
        end
    end

    assign slotWinner = winner;
    // Head leaves the buffer on the same edge it is sent
    assign fifoPop    = (winner == INSERT);

    // Next ring slot contents
    always_comb begin
        case (winner)
            FORWARD: nextOut = ringIn;
            INSERT:  nextOut = fifoHead;
            default: nextOut = '0;
        endcase
    end

    // Next core response, thread id from low requestor bits
    always_comb begin
        nextRsp.valid    = rspMatch;
        nextRsp.opcode   = ringIn.opcode;
        nextRsp.data     = ringIn.data;
        nextRsp.threadId = ringIn.requestor[THREAD_ID_W-1:0];
    end

    //----------------------------------------------------------
    // Output registers, one cycle through the stop
    //----------------------------------------------------------
    always_ff @(posedge QClk) begin
        ringOut <= nextOut;
        coreRsp <= nextRsp;
        if (reset) begin
            ringOut.valid <= 1'b0;
            coreRsp.valid <= 1'b0;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ring node testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f filelist.f --top-module ringNodeTb -Mdir obj_dir
./obj_dir/VringNodeTb > sim.log
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi

// ==== sim/ringNodeChecker.sv ====
//----------------------------------------------------------
// Ring node checker
// Reference model of the node and comparison on every edge
//----------------------------------------------------------
`timescale 1ns/1ps

module ringNodeChecker
    import lotrCfgPkg::*;
    import lotrPkg::*;
(
    input  logic                 QClk,
    input  logic                 reset,
    input  logic [CORE_ID_W-1:0] coreId,
    input  tCoreReq              coreReq,
    input  tRingMsg              ringIn,
    input  tRingMsg              ringOut,
    input  tCoreRsp              coreRsp,
    input  logic                 coreStall,
    input  tWinner               slotWinner,
    output int                   mismatchCount,
    output logic                 modelIdle
);

    // Expected buffer contents with the oldest first
    tRingMsg fifoQ [$];
    // Request held in the tagging register
    tRingMsg stageMsg;
    // Expected outputs after the current edge
    tRingMsg expOut;
    tCoreRsp expRsp;
    logic    checkOn;

    initial begin
        mismatchCount = 0;
        modelIdle     = 1'b0;
        checkOn       = 1'b0;
        stageMsg      = '0;
        expOut        = '0;
        expRsp        = '0;
    end

    task automatic reportMismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        mismatchCount++;
    endtask

    //----------------------------------------------------------
    // Compare then step the model
    //----------------------------------------------------------
    always @(posedge QClk) begin : modelStep
        logic   rspHit;
        logic   full;
        tWinner expWinner;
        // Outputs before this edge come from the last decision
        if (checkOn) begin
            if (ringOut.valid !== expOut.valid || (expOut.valid && ringOut !== expOut)) begin
                reportMismatch($sformatf("ringOut %h, expected %h", ringOut, expOut));
            end
            if (coreRsp.valid !== expRsp.valid || (expRsp.valid && coreRsp !== expRsp)) begin
                reportMismatch($sformatf("coreRsp %h, expected %h", coreRsp, expRsp));
            end
            if (coreStall !== (fifoQ.size() == REQ_FIFO_DEPTH)) begin
                reportMismatch($sformatf("coreStall %b, buffer holds %0d", coreStall,
                    fifoQ.size()));
            end
        end
        if (reset) begin
            fifoQ.delete();
            stageMsg = '0;
            expOut   = '0;
            expRsp   = '0;
            checkOn  = 1'b1;
        end else begin
            // Response for this core leaves the ring
            rspHit = ringIn.valid && (ringIn.opcode == RD_RSP || ringIn.opcode == WR_RSP)
                && ringIn.requestor[REQUESTOR_W-1:THREAD_ID_W] == coreId;
            full   = (fifoQ.size() == REQ_FIFO_DEPTH);
            expRsp = '0;
            if (rspHit) begin
                expRsp.valid    = 1'b1;
                expRsp.opcode   = ringIn.opcode;
                expRsp.data     = ringIn.data;
                expRsp.threadId = ringIn.requestor[THREAD_ID_W-1:0];
            end
            // Passing traffic wins over the oldest request
            if (ringIn.valid && !rspHit) begin
                expOut    = ringIn;
                expWinner = FORWARD;
            end else if (fifoQ.size() != 0) begin
                expOut    = fifoQ.pop_front();
                expWinner = INSERT;
            end else begin
                expOut    = '0;
                expWinner = rspHit ? EJECT : IDLE;
            end
            // Slot decision is seen before the edge
            if (slotWinner !== expWinner) begin
                reportMismatch($sformatf("slotWinner %0d, expected %0d", slotWinner,
                    expWinner));
            end
            // Push lands after the pop and is dropped when full
            if (stageMsg.valid && !full) begin
                fifoQ.push_back(stageMsg);
            end
            stageMsg.valid     = coreReq.valid;
            stageMsg.opcode    = coreReq.opcode;
            stageMsg.requestor = {coreId, coreReq.threadId};
            stageMsg.address   = coreReq.address;
            stageMsg.data      = coreReq.data;
        end
        modelIdle = (fifoQ.size() == 0) && !stageMsg.valid && !expOut.valid;
    end

endmodule

// ==== sim/ringNodeTb.sv ====
//----------------------------------------------------------
// Ring node testbench
// Clock, reset, LFSR stimulus and the node under test
//----------------------------------------------------------
`timescale 1ns/1ps

module ringNodeTb
    import lotrCfgPkg::*;
    import lotrPkg::*;
();

    localparam logic [CORE_ID_W-1:0] NODE_ID = 8'h5A;
    localparam int WAIT_LIMIT = 300;

    logic                 QClk;
    logic                 reset;
    logic [CORE_ID_W-1:0] coreId;
    tCoreReq              coreReq;
    logic                 coreStall;
    tCoreRsp              coreRsp;
    tRingMsg              ringIn;
    tRingMsg              ringOut;
    tWinner               slotWinner;
    int                   mismatchCount;
    logic                 modelIdle;

    logic [15:0] lfsr;
    int          passCount;
    int          failCount;
    int          errMark;
    logic        timedOut;

    // 40 ns period
    always #20 QClk = ~QClk;

    ringNode u_dut (
        .QClk(QClk), .reset(reset), .coreId(coreId), .coreReq(coreReq),
        .coreStall(coreStall), .coreRsp(coreRsp), .ringIn(ringIn),
        .ringOut(ringOut), .slotWinner(slotWinner)
    );

    ringNodeChecker u_checker (
        .QClk(QClk), .reset(reset), .coreId(coreId), .coreReq(coreReq),
        .ringIn(ringIn), .ringOut(ringOut), .coreRsp(coreRsp),
        .coreStall(coreStall), .slotWinner(slotWinner),
        .mismatchCount(mismatchCount), .modelIdle(modelIdle)
    );

    // Fibonacci LFSR with taps 16 14 13 11
    // One step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Own core id about half the time
    function automatic tRingMsg randomRingMsg();
        tRingMsg              m;
        logic [CORE_ID_W-1:0] id;
        m.valid  = 1'(takeBits(1));
        m.opcode = tOpcode'(2'(takeBits(2)));
        id       = (takeBits(1) != 0) ? NODE_ID : CORE_ID_W'(takeBits(CORE_ID_W));
        m.requestor = {id, THREAD_ID_W'(takeBits(THREAD_ID_W))};
        m.address   = takeBits(DATA_W);
        m.data      = takeBits(DATA_W);
        return m;
    endfunction

    task automatic startTest();
        errMark  = mismatchCount;
        timedOut = 1'b0;
    endtask

    task automatic finishTest(input string name);
        if (mismatchCount == errMark && !timedOut) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: not ok, %0d mismatches", name, mismatchCount - errMark);
        end
    endtask

    // Bounded wait for a stall level
    task automatic waitStall(input logic level, input string what);
        int n;
        n = 0;
        while (coreStall !== level && n < WAIT_LIMIT) begin
            @(negedge QClk);
            n++;
        end
        if (coreStall !== level) begin
            $display("timeout at %0t waiting for %s", $time, what);
            timedOut = 1'b1;
        end
    endtask

    // Model empty means every request reached the ring
    task automatic waitDrain(input string what);
        int n;
        n = 0;
        while (modelIdle !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge QClk);
            n++;
        end
        if (modelIdle !== 1'b1) begin
            $display("timeout at %0t, requests still pending in %s", $time, what);
            timedOut = 1'b1;
        end
    endtask

    task automatic runTraffic(input int cycles, input logic withCore);
        tCoreReq req;
        for (int c = 0; c < cycles; c++) begin
            ringIn = randomRingMsg();
            req    = '0;
            // No request while the buffer is full
            if (withCore && !coreStall) begin
                req.valid    = 1'(takeBits(1));
                req.opcode   = tOpcode'(2'(takeBits(1)));
                req.address  = takeBits(DATA_W);
                req.data     = takeBits(DATA_W);
                req.threadId = THREAD_ID_W'(takeBits(THREAD_ID_W));
            end
            coreReq = req;
            @(negedge QClk);
        end
        coreReq = '0;
        ringIn  = '0;
    endtask

    //----------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------
    initial begin
        QClk      = 1'b0;
        reset     = 1'b1;
        coreId    = NODE_ID;
        coreReq   = '0;
        ringIn    = '0;
        lfsr      = 16'd49704;
        passCount = 0;
        failCount = 0;

        startTest();
        repeat (10) @(negedge QClk);
        reset = 1'b0;
        repeat (2) @(negedge QClk);
        finishTest("reset");

        // Ring traffic only with forwards and ejects
        startTest();
        runTraffic(200, 1'b0);
        waitDrain("forward and eject");
        finishTest("forward and eject");

        startTest();
        runTraffic(400, 1'b1);
        waitDrain("insert");
        finishTest("insert order and tagging");

        // Passing requests fill every slot
        startTest();
        for (int i = 0; i < REQ_FIFO_DEPTH + 1; i++) begin
            ringIn        = randomRingMsg();
            ringIn.valid  = 1'b1;
            ringIn.opcode = RD;
            coreReq       = '0;
            if (!coreStall) begin
                coreReq.valid    = 1'b1;
                coreReq.opcode   = tOpcode'(2'(takeBits(1)));
                coreReq.address  = takeBits(DATA_W);
                coreReq.data     = takeBits(DATA_W);
                coreReq.threadId = THREAD_ID_W'(i);
            end
            @(negedge QClk);
        end
        coreReq = '0;
        waitStall(1'b1, "coreStall to rise");
        repeat (4) @(negedge QClk);
        ringIn = '0;
        waitStall(1'b0, "coreStall to fall");
        waitDrain("stall");
        finishTest("stall");

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
